/* source/ooo_pkg.sv */
package ooo_pkg;

    //////////////////////////////
    // widths
    typedef logic [31:0] xlen_t;     // data word
    typedef logic [31:0] inst_t;     // rv32i instruction word
    typedef logic [4:0]  reg_idx_t;  // x0..x31
    typedef logic [2:0]  rob_tag_t;  // rob slot, also the rename tag

    //////////////////////////////
    // sizes
    localparam int ROB_DEPTH = 8;
    localparam int RS_DEPTH  = 4;
    localparam int REG_COUNT = 32;

    //////////////////////////////
    // rv32i encodings
    localparam logic [6:0] OPC_OP     = 7'b0110011; // reg-reg
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // reg-imm

    localparam logic [2:0] F3_ADD = 3'b000; // add, sub, addi
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // selects sub

    // alu operations
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4
    } alu_op_t;

endpackage

/* source/rs_dispatch_if.sv */
interface rs_dispatch_if;
    import ooo_pkg::*;

    logic     valid;       // one renamed instr this cycle
    alu_op_t  op;
    rob_tag_t dest;        // rob slot of the result
    xlen_t    src1_value;
    logic     src1_ready;
    rob_tag_t src1_tag;    // producer when not ready
    xlen_t    src2_value;  // immediate lands here
    logic     src2_ready;
    rob_tag_t src2_tag;

    modport dispatch (output valid, op, dest, src1_value, src1_ready, src1_tag,
                      output src2_value, src2_ready, src2_tag);
    modport station  (input valid, op, dest, src1_value, src1_ready, src1_tag,
                      input src2_value, src2_ready, src2_tag);
endinterface

/* source/register_alias_table.sv */
module register_alias_table (
    input  logic               clock,
    input  logic               reset,
    input  ooo_pkg::reg_idx_t  src1_reg,
    input  ooo_pkg::reg_idx_t  src2_reg,
    output ooo_pkg::xlen_t     src1_value,
    output logic               src1_busy,
    output ooo_pkg::rob_tag_t  src1_tag,
    output ooo_pkg::xlen_t     src2_value,
    output logic               src2_busy,
    output ooo_pkg::rob_tag_t  src2_tag,
    input  logic               rename_en,
    input  ooo_pkg::reg_idx_t  rename_reg,
    input  ooo_pkg::rob_tag_t  rename_tag,
    input  logic               commit_en,
    input  ooo_pkg::reg_idx_t  commit_reg,
    input  ooo_pkg::rob_tag_t  commit_tag,
    input  ooo_pkg::xlen_t     commit_data
);
    import ooo_pkg::*;

    xlen_t               regs [REG_COUNT]; // architectural state
    logic [REG_COUNT-1:0] busy;            // result still in flight
    rob_tag_t            tag  [REG_COUNT]; // newest producer

    logic commit_hit;

    // only the newest producer may retire into the map
    assign commit_hit = commit_en && busy[commit_reg] && (tag[commit_reg] == commit_tag);

    assign src1_value = regs[src1_reg];
    assign src1_busy  = busy[src1_reg];
    assign src1_tag   = tag[src1_reg];
    assign src2_value = regs[src2_reg];
    assign src2_busy  = busy[src2_reg];
    assign src2_tag   = tag[src2_reg];

    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= '0;
            for (int i = 0; i < REG_COUNT; i++) regs[i] <= '0;
        end else begin
            if (commit_hit) begin
                regs[commit_reg] <= commit_data;
                busy[commit_reg] <= 1'b0;
            end
            // rename wins over a same-cycle commit, x0 never renamed
            if (rename_en && rename_reg != '0) busy[rename_reg] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (rename_en && rename_reg != '0) tag[rename_reg] <= rename_tag;
    end
endmodule

/* source/dispatcher.sv */
module dispatcher (
    input  logic               clock,
    input  logic               reset,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  ooo_pkg::inst_t     wb_dat,
    output logic               wb_ack,
    rs_dispatch_if.dispatch    rs,
    input  logic               rs_has_space,
    input  logic               rob_has_space,
    output logic               alloc,
    output ooo_pkg::reg_idx_t  alloc_reg,
    input  ooo_pkg::rob_tag_t  alloc_tag,
    output ooo_pkg::reg_idx_t  src1_reg,
    output ooo_pkg::reg_idx_t  src2_reg,
    input  ooo_pkg::xlen_t     src1_value,
    input  logic               src1_busy,
    input  ooo_pkg::rob_tag_t  src1_tag,
    input  ooo_pkg::xlen_t     src2_value,
    input  logic               src2_busy,
    input  ooo_pkg::rob_tag_t  src2_tag,
    output ooo_pkg::rob_tag_t  fwd_tag1,
    output ooo_pkg::rob_tag_t  fwd_tag2,
    input  logic               fwd_done1,
    input  logic               fwd_done2,
    input  ooo_pkg::xlen_t     fwd_value1,
    input  ooo_pkg::xlen_t     fwd_value2,
    input  logic               cdb_valid,
    input  ooo_pkg::rob_tag_t  cdb_tag,
    input  ooo_pkg::xlen_t     cdb_value
);
    import ooo_pkg::*;

    logic    ack_q;
    logic    legal;
    logic    is_imm;
    alu_op_t op;
    xlen_t   imm;
    xlen_t   rs1_val;
    xlen_t   rs2_val;
    logic    rs1_rdy;
    logic    rs2_rdy;

    // operand source: regfile, then rob, then cdb, else wait on tag
    function automatic void resolve(input reg_idx_t r, input xlen_t rf_val, input logic busy,
                                    input rob_tag_t tag, input logic fdone, input xlen_t fval,
                                    input logic cv, input rob_tag_t ct, input xlen_t cval,
                                    output xlen_t val, output logic rdy);
        rdy = 1'b1;
        if (r == '0)                val = '0;     // x0 reads zero
        else if (!busy)             val = rf_val;
        else if (fdone)             val = fval;
        else if (cv && ct == tag)   val = cval;   // result on the bus right now
        else begin
            val = '0;
            rdy = 1'b0;
        end
    endfunction

    //////////////////////////////
    // wishbone slave
    always_ff @(posedge clock) begin
        if (reset) ack_q <= 1'b0;
        else       ack_q <= wb_cyc && wb_stb && !ack_q && rob_has_space && rs_has_space;
    end
    assign wb_ack = ack_q;

    //////////////////////////////
    // decode
    always_comb begin
        legal  = 1'b0;
        is_imm = 1'b0;
        op     = ALU_ADD;
        if (wb_we && wb_dat[6:0] == OPC_OP) begin
            legal = 1'b1;
            case ({wb_dat[31:25], wb_dat[14:12]})
                {F7_BASE, F3_ADD}: op = ALU_ADD;
                {F7_ALT,  F3_ADD}: op = ALU_SUB;
                {F7_BASE, F3_AND}: op = ALU_AND;
                {F7_BASE, F3_OR}:  op = ALU_OR;
                {F7_BASE, F3_XOR}: op = ALU_XOR;
                default:           legal = 1'b0;  // mul and friends dropped
            endcase
        end else if (wb_we && wb_dat[6:0] == OPC_OP_IMM && wb_dat[14:12] == F3_ADD) begin
            legal  = 1'b1;  // addi only
            is_imm = 1'b1;
        end
    end

    assign imm = {{20{wb_dat[31]}}, wb_dat[31:20]}; // i-type, sign extended

    assign src1_reg  = wb_dat[19:15];
    assign src2_reg  = wb_dat[24:20];
    assign alloc_reg = wb_dat[11:7];
    assign fwd_tag1  = src1_tag;
    assign fwd_tag2  = src2_tag;

    // illegal words still get acked, just never allocated
    assign alloc = ack_q && legal;

    always_comb begin
        resolve(src1_reg, src1_value, src1_busy, src1_tag, fwd_done1, fwd_value1,
                cdb_valid, cdb_tag, cdb_value, rs1_val, rs1_rdy);
        resolve(src2_reg, src2_value, src2_busy, src2_tag, fwd_done2, fwd_value2,
                cdb_valid, cdb_tag, cdb_value, rs2_val, rs2_rdy);
    end

    //////////////////////////////
    // to the reservation station
    assign rs.valid      = alloc;
    assign rs.op         = op;
    assign rs.dest       = alloc_tag;
    assign rs.src1_value = rs1_val;
    assign rs.src1_ready = rs1_rdy;
    assign rs.src1_tag   = src1_tag;
    assign rs.src2_value = is_imm ? imm : rs2_val;
    assign rs.src2_ready = is_imm || rs2_rdy;
    assign rs.src2_tag   = src2_tag;  // ignored once ready
endmodule

/* source/reservation_station.sv */
module reservation_station (
    input  logic               clock,
    input  logic               reset,
    rs_dispatch_if.station     rs,
    output logic               rs_has_space,
    input  logic               cdb_valid,
    input  ooo_pkg::rob_tag_t  cdb_tag,
    input  ooo_pkg::xlen_t     cdb_value,
    output logic               issue_valid,
    output ooo_pkg::alu_op_t   issue_op,
    output ooo_pkg::xlen_t     issue_a,
    output ooo_pkg::xlen_t     issue_b,
    output ooo_pkg::rob_tag_t  issue_tag
);
    import ooo_pkg::*;

    localparam int IDX_W = $clog2(RS_DEPTH);

    logic [RS_DEPTH-1:0] valid;
    alu_op_t             op    [RS_DEPTH];
    rob_tag_t            dest  [RS_DEPTH];
    xlen_t               a_val [RS_DEPTH];
    xlen_t               b_val [RS_DEPTH];
    rob_tag_t            a_tag [RS_DEPTH];
    rob_tag_t            b_tag [RS_DEPTH];
    logic [RS_DEPTH-1:0] a_rdy;
    logic [RS_DEPTH-1:0] b_rdy;
    logic [IDX_W-1:0]    free_idx;
    logic [IDX_W-1:0]    issue_idx;

    // lowest free slot and lowest ready slot, scan down so index 0 wins
    always_comb begin
        free_idx     = '0;
        issue_idx    = '0;
        rs_has_space = 1'b0;
        issue_valid  = 1'b0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                free_idx     = IDX_W'(i);
                rs_has_space = 1'b1;
            end
            if (valid[i] && a_rdy[i] && b_rdy[i]) begin
                issue_idx   = IDX_W'(i);
                issue_valid = 1'b1;
            end
        end
    end

    assign issue_op  = op[issue_idx];
    assign issue_a   = a_val[issue_idx];
    assign issue_b   = b_val[issue_idx];
    assign issue_tag = dest[issue_idx];

    always_ff @(posedge clock) begin
        if (reset) valid <= '0;
        else begin
            if (issue_valid) valid[issue_idx] <= 1'b0;
            if (rs.valid)    valid[free_idx]  <= 1'b1;  // never the issuing slot
        end
    end

    always_ff @(posedge clock) begin
        // cdb wakeup of waiting operands
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (cdb_valid && valid[i] && !a_rdy[i] && a_tag[i] == cdb_tag) begin
                a_val[i] <= cdb_value;
                a_rdy[i] <= 1'b1;
            end
            if (cdb_valid && valid[i] && !b_rdy[i] && b_tag[i] == cdb_tag) begin
                b_val[i] <= cdb_value;
                b_rdy[i] <= 1'b1;
            end
        end
        if (rs.valid) begin
            op[free_idx]    <= rs.op;
            dest[free_idx]  <= rs.dest;
            a_val[free_idx] <= rs.src1_value;
            a_rdy[free_idx] <= rs.src1_ready;
            a_tag[free_idx] <= rs.src1_tag;
            b_val[free_idx] <= rs.src2_value;
            b_rdy[free_idx] <= rs.src2_ready;
            b_tag[free_idx] <= rs.src2_tag;
        end
    end
endmodule

/* source/alu_unit.sv */
module alu_unit (
    input  logic               clock,
    input  logic               reset,
    input  logic               issue_valid,
    input  ooo_pkg::alu_op_t   issue_op,
    input  ooo_pkg::xlen_t     issue_a,
    input  ooo_pkg::xlen_t     issue_b,
    input  ooo_pkg::rob_tag_t  issue_tag,
    output logic               cdb_valid,
    output ooo_pkg::rob_tag_t  cdb_tag,
    output ooo_pkg::xlen_t     cdb_value
);
    import ooo_pkg::*;

    xlen_t result;

    always_comb begin
        case (issue_op)
            ALU_ADD: result = issue_a + issue_b;
            ALU_SUB: result = issue_a - issue_b;
            ALU_AND: result = issue_a & issue_b;
            ALU_OR:  result = issue_a | issue_b;
            ALU_XOR: result = issue_a ^ issue_b;
            default: result = '0;
        endcase
    end

    // execute register, its outputs are the cdb
    always_ff @(posedge clock) begin
        if (reset) cdb_valid <= 1'b0;
        else       cdb_valid <= issue_valid;
    end

    always_ff @(posedge clock) begin
        cdb_tag   <= issue_tag;
        cdb_value <= result;
    end
endmodule

/* source/reorder_buffer.sv */
module reorder_buffer (
    input  logic               clock,
    input  logic               reset,
    input  logic               alloc,
    input  ooo_pkg::reg_idx_t  alloc_reg,
    output ooo_pkg::rob_tag_t  alloc_tag,
    output logic               rob_has_space,
    input  logic               cdb_valid,
    input  ooo_pkg::rob_tag_t  cdb_tag,
    input  ooo_pkg::xlen_t     cdb_value,
    input  ooo_pkg::rob_tag_t  fwd_tag1,
    input  ooo_pkg::rob_tag_t  fwd_tag2,
    output logic               fwd_done1,
    output logic               fwd_done2,
    output ooo_pkg::xlen_t     fwd_value1,
    output ooo_pkg::xlen_t     fwd_value2,
    output logic               commit_valid,
    output ooo_pkg::reg_idx_t  commit_reg,
    output ooo_pkg::rob_tag_t  commit_tag,
    output ooo_pkg::xlen_t     commit_data
);
    import ooo_pkg::*;

    localparam int CNT_W = $clog2(ROB_DEPTH) + 1;

    rob_tag_t             head;   // oldest entry
    rob_tag_t             tail;   // next free slot
    logic [CNT_W-1:0]     count;
    logic [ROB_DEPTH-1:0] done;
    reg_idx_t             dst_reg [ROB_DEPTH];
    xlen_t                value   [ROB_DEPTH];

    assign alloc_tag     = tail;
    assign rob_has_space = count != CNT_W'(ROB_DEPTH);

    //////////////////////////////
    // forwarding reads
    assign fwd_done1  = done[fwd_tag1];
    assign fwd_value1 = value[fwd_tag1];
    assign fwd_done2  = done[fwd_tag2];
    assign fwd_value2 = value[fwd_tag2];

    //////////////////////////////
    // in-order commit
    assign commit_valid = (count != '0) && done[head];  // done bit only trusted when occupied
    assign commit_reg   = dst_reg[head];
    assign commit_tag   = head;
    assign commit_data  = value[head];

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (alloc)        tail <= tail + rob_tag_t'(1);  // wraps at depth
            if (commit_valid) head <= head + rob_tag_t'(1);
            count <= count + CNT_W'(alloc) - CNT_W'(commit_valid);
        end
    end

    always_ff @(posedge clock) begin
        if (alloc) begin
            done[tail]    <= 1'b0;
            dst_reg[tail] <= alloc_reg;
        end
        // cdb tag is always in flight, never the slot being allocated
        if (cdb_valid) begin
            done[cdb_tag]  <= 1'b1;
            value[cdb_tag] <= cdb_value;
        end
    end
endmodule

/* source/ooo_core.sv */
module ooo_core (
    input  logic               clock,
    input  logic               reset,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  ooo_pkg::inst_t     wb_dat,
    output logic               wb_ack,
    output logic               commit_valid,
    output ooo_pkg::reg_idx_t  commit_reg,
    output ooo_pkg::xlen_t     commit_data
);
    import ooo_pkg::*;

    logic     rs_has_space, rob_has_space, alloc;
    reg_idx_t alloc_reg, src1_reg, src2_reg;
    rob_tag_t alloc_tag, src1_tag, src2_tag, fwd_tag1, fwd_tag2, commit_tag;
    xlen_t    src1_value, src2_value, fwd_value1, fwd_value2;
    logic     src1_busy, src2_busy, fwd_done1, fwd_done2;
    logic     cdb_valid, issue_valid;
    rob_tag_t cdb_tag, issue_tag;
    xlen_t    cdb_value, issue_a, issue_b;
    alu_op_t  issue_op;

    rs_dispatch_if rs_bus ();

    dispatcher dispatch0 (.clock, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_dat, .wb_ack,
        .rs(rs_bus.dispatch), .rs_has_space, .rob_has_space, .alloc, .alloc_reg, .alloc_tag,
        .src1_reg, .src2_reg, .src1_value, .src1_busy, .src1_tag,
        .src2_value, .src2_busy, .src2_tag, .fwd_tag1, .fwd_tag2, .fwd_done1, .fwd_done2,
        .fwd_value1, .fwd_value2, .cdb_valid, .cdb_tag, .cdb_value);

    register_alias_table rat0 (.clock, .reset, .src1_reg, .src2_reg,
        .src1_value, .src1_busy, .src1_tag, .src2_value, .src2_busy, .src2_tag,
        .rename_en(alloc), .rename_reg(alloc_reg), .rename_tag(alloc_tag),
        .commit_en(commit_valid), .commit_reg, .commit_tag, .commit_data);

    reservation_station rs0 (.clock, .reset, .rs(rs_bus.station), .rs_has_space,
        .cdb_valid, .cdb_tag, .cdb_value,
        .issue_valid, .issue_op, .issue_a, .issue_b, .issue_tag);

    alu_unit alu0 (.clock, .reset, .issue_valid, .issue_op, .issue_a, .issue_b, .issue_tag,
        .cdb_valid, .cdb_tag, .cdb_value);

    reorder_buffer rob0 (.clock, .reset, .alloc, .alloc_reg, .alloc_tag, .rob_has_space,
        .cdb_valid, .cdb_tag, .cdb_value, .fwd_tag1, .fwd_tag2, .fwd_done1, .fwd_done2,
        .fwd_value1, .fwd_value2, .commit_valid, .commit_reg, .commit_tag, .commit_data);
endmodule

/* dv/ooo_core_assert.sv */
module ooo_core_assert (
    input logic clock,
    input logic reset,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic commit_valid
);
    int acks;     // words taken so far
    int commits;  // instructions retired so far

    always_ff @(posedge clock) begin
        if (reset) begin
            acks    <= 0;
            commits <= 0;
        end else begin
            acks    <= acks + (wb_ack ? 1 : 0);
            commits <= commits + (commit_valid ? 1 : 0);
        end
    end

    //////////////////////////////
    ack_needs_stb: assert property (@(posedge clock) disable iff (reset)
        wb_ack |-> wb_cyc && wb_stb) else $error("wb_ack high without cyc and stb");

    // retire never runs ahead of the bus
    commits_bounded: assert property (@(posedge clock) disable iff (reset)
        (commits + (commit_valid ? 1 : 0)) <= acks) else $error("more commits than acks");

    quiet_after_reset: assert property (@(posedge clock)
        $fell(reset) |-> !wb_ack && !commit_valid) else $error("activity right after reset");
endmodule

bind ooo_core ooo_core_assert assert0 (.clock, .reset, .wb_cyc, .wb_stb, .wb_ack,
    .commit_valid);

/* dv/ooo_core_tb.sv */
module ooo_core_tb;
    import ooo_pkg::*;

    localparam int DRIVE_DELAY  = 1;   // after the rising edge
    localparam int RESET_CYCLES = 10;
    localparam int BURST_FIRST  = 17;  // rows from here on go without idle gaps

    logic     clock;
    logic     reset;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    inst_t    wb_dat;
    logic     wb_ack;
    logic     commit_valid;
    reg_idx_t commit_reg;
    xlen_t    commit_data;

    // stimulus table with one row per bus write
    inst_t    row_word  [$];
    logic     row_legal [$];
    reg_idx_t row_reg   [$];
    xlen_t    row_val   [$];

    reg_idx_t exp_reg [$];  // owed commits in program order
    xlen_t    exp_val [$];

    int   seed;
    int   cycles      = 0;
    int   cycle_limit = 0;
    int   commits     = 0;
    int   legal_rows  = 0;
    logic stb_seen    = 1'b0;  // quiet check ends at the first write

    ooo_core dut0 (.clock, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_dat, .wb_ack,
        .commit_valid, .commit_reg, .commit_data);

    //////////////////////////////
    // helpers
    function automatic inst_t r_type_word(input logic [6:0] f7, input logic [2:0] f3,
                                          input reg_idx_t rd, input reg_idx_t rs1,
                                          input reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic inst_t addi_word(input reg_idx_t rd, input reg_idx_t rs1,
                                        input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    task automatic add_row(input inst_t word, input logic legal, input reg_idx_t rd,
                           input xlen_t value);
        row_word.push_back(word);
        row_legal.push_back(legal);
        row_reg.push_back(rd);
        row_val.push_back(value);
        if (legal) legal_rows++;
    endtask

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t want);
        if (got !== want)
            stop_with_failure($sformatf("FAILED at %0t: %s got %0d expected %0d",
                                        $time, name, got, want));
    endtask

    task automatic check_data(input string name, input xlen_t got, input xlen_t want);
        if (got !== want)
            stop_with_failure($sformatf("FAILED at %0t: %s got 0x%08h expected 0x%08h",
                                        $time, name, got, want));
    endtask

    // classic write held until ack plus one idle cycle with stb low
    task automatic wb_write(input inst_t word);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_dat   = word;
        stb_seen = 1'b1;
        do begin
            @(posedge clock);
            #DRIVE_DELAY;
        end while (!wb_ack);
        @(posedge clock);  // word taken on this edge
        #DRIVE_DELAY;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(posedge clock);
        #DRIVE_DELAY;
    endtask

    //////////////////////////////
    // program with values worked out by hand in program order
    task automatic build_table();
        add_row(addi_word(5'd1, 5'd0, 12'd5),    1'b1, 5'd1, 32'h0000_0005);
        add_row(addi_word(5'd2, 5'd0, 12'd12),   1'b1, 5'd2, 32'h0000_000c);
        add_row(addi_word(5'd3, 5'd0, 12'hffd),  1'b1, 5'd3, 32'hffff_fffd); // -3
        add_row(addi_word(5'd4, 5'd0, 12'h7ff),  1'b1, 5'd4, 32'h0000_07ff);
        add_row(r_type_word(7'h00, 3'b000, 5'd5, 5'd1, 5'd2), 1'b1, 5'd5, 32'h0000_0011);
        add_row(r_type_word(7'h20, 3'b000, 5'd6, 5'd5, 5'd1), 1'b1, 5'd6, 32'h0000_000c);
        add_row(r_type_word(7'h00, 3'b111, 5'd7, 5'd6, 5'd3), 1'b1, 5'd7, 32'h0000_000c);
        add_row(r_type_word(7'h00, 3'b110, 5'd8, 5'd7, 5'd1), 1'b1, 5'd8, 32'h0000_000d);
        add_row(r_type_word(7'h00, 3'b100, 5'd9, 5'd8, 5'd4), 1'b1, 5'd9, 32'h0000_07f2);
        add_row(r_type_word(7'h01, 3'b000, 5'd10, 5'd1, 5'd2), 1'b0, 5'd0, 32'h0); // mul
        add_row(r_type_word(7'h20, 3'b000, 5'd10, 5'd3, 5'd9), 1'b1, 5'd10, 32'hffff_f80b);
        add_row(r_type_word(7'h00, 3'b000, 5'd1, 5'd1, 5'd1),  1'b1, 5'd1, 32'h0000_000a);
        add_row(32'h0040_a183, 1'b0, 5'd0, 32'h0);                              // lw
        add_row(r_type_word(7'h00, 3'b100, 5'd11, 5'd1, 5'd5), 1'b1, 5'd11, 32'h0000_001b);
        add_row(addi_word(5'd0, 5'd0, 12'd99),   1'b1, 5'd0, 32'h0000_0063); // x0 still commits
        add_row(r_type_word(7'h00, 3'b000, 5'd12, 5'd0, 5'd5), 1'b1, 5'd12, 32'h0000_0011);
        add_row(r_type_word(7'h00, 3'b000, 5'd13, 5'd0, 5'd0), 1'b1, 5'd13, 32'h0);
        // back to back burst longer than the rob
        add_row(addi_word(5'd14, 5'd0, 12'd1),   1'b1, 5'd14, 32'h0000_0001);
        add_row(r_type_word(7'h00, 3'b000, 5'd14, 5'd14, 5'd14), 1'b1, 5'd14, 32'h0000_0002);
        add_row(r_type_word(7'h00, 3'b000, 5'd14, 5'd14, 5'd14), 1'b1, 5'd14, 32'h0000_0004);
        add_row(r_type_word(7'h00, 3'b000, 5'd15, 5'd14, 5'd12), 1'b1, 5'd15, 32'h0000_0015);
        add_row(r_type_word(7'h20, 3'b000, 5'd16, 5'd15, 5'd14), 1'b1, 5'd16, 32'h0000_0011);
        add_row(r_type_word(7'h00, 3'b110, 5'd17, 5'd16, 5'd2),  1'b1, 5'd17, 32'h0000_001d);
        add_row(r_type_word(7'h00, 3'b111, 5'd18, 5'd17, 5'd15), 1'b1, 5'd18, 32'h0000_0015);
        add_row(r_type_word(7'h00, 3'b100, 5'd19, 5'd18, 5'd10), 1'b1, 5'd19, 32'hffff_f81e);
        add_row(r_type_word(7'h00, 3'b000, 5'd20, 5'd19, 5'd3),  1'b1, 5'd20, 32'hffff_f81b);
        add_row(addi_word(5'd21, 5'd20, 12'd5),  1'b1, 5'd21, 32'hffff_f820);
        add_row(r_type_word(7'h20, 3'b000, 5'd22, 5'd21, 5'd20), 1'b1, 5'd22, 32'h0000_0005);
    endtask

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // run limit scales with the table
    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit)
            stop_with_failure($sformatf("timeout, run did not finish in %0d cycles",
                                        cycle_limit));
    end

    // commit port is settled by the falling edge
    always @(negedge clock) begin
        if (!reset && !stb_seen && (wb_ack || commit_valid))
            stop_with_failure("ack or commit seen before the first bus write");
        else if (!reset && commit_valid) begin
            if (exp_reg.size() == 0)
                stop_with_failure("commit seen with no accepted instruction pending");
            else begin
                check_reg("commit_reg", commit_reg, exp_reg.pop_front());
                check_data("commit_data", commit_data, exp_val.pop_front());
                commits++;
            end
        end
    end

    initial begin
        int gap;
        reset  = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        wb_dat = '0;
        seed   = 29645;
        build_table();
        cycle_limit = 40 * row_word.size() + 100;
        repeat (RESET_CYCLES) @(posedge clock);
        #DRIVE_DELAY;
        reset = 1'b0;
        repeat (3) @(posedge clock);  // idle cycles where the bus stays quiet
        #DRIVE_DELAY;
        for (int i = 0; i < row_word.size(); i++) begin
            wb_write(row_word[i]);
            if (row_legal[i]) begin
                exp_reg.push_back(row_reg[i]);
                exp_val.push_back(row_val[i]);
            end
            gap = (i >= BURST_FIRST) ? 0 : $unsigned($random(seed)) % 4;
            repeat (gap) begin
                @(posedge clock);
                #DRIVE_DELAY;
            end
        end
        while (exp_reg.size() != 0) @(posedge clock);
        repeat (20) @(posedge clock);  // room for a stray extra commit
        if (commits != legal_rows)
            stop_with_failure($sformatf("saw %0d commits for %0d legal words",
                                        commits, legal_rows));
        else begin
            $display("Simulation PASSED");
            $finish;
        end
    end
endmodule

/* src.f */
source/ooo_pkg.sv
source/rs_dispatch_if.sv
source/register_alias_table.sv
source/dispatcher.sv
source/reservation_station.sv
source/alu_unit.sv
source/reorder_buffer.sv
source/ooo_core.sv
dv/ooo_core_assert.sv
dv/ooo_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the ooo_core testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module ooo_core_tb -f src.f -o sim_ooo_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_ooo_core > sim.log 2>&1
status=$?
cat sim.log
if grep -q "Simulation FAILED" sim.log || [ $status -ne 0 ]; then
    echo "simulation reported failure"
    exit 1
fi
exit 0
